// ==== source/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    //////////////////////////////
    // widths and counts
    //////////////////////////////

    localparam int NUM_ARCH     = 32;
    localparam int LANES        = 4;
    localparam int RETIRE_PORTS = 2;

    typedef logic [4:0] arch_reg_t;
    typedef logic [6:0] phys_reg_t;
    typedef logic [1:0] lane_idx_t;

    //////////////////////////////
    // lane payloads
    //////////////////////////////

    // one decoded instruction
    typedef struct packed {
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      write_rd;
    } decode_lane_t;

    // operand source is the table or an earlier lane's new register
    typedef struct packed {
        logic      bypass;
        lane_idx_t lane;
    } src_sel_t;

    typedef struct packed {
        src_sel_t rs1;
        src_sel_t rs2;
        src_sel_t old_rd;
    } lane_sel_t;

    typedef struct packed {
        phys_reg_t rs1_phys;
        phys_reg_t rs2_phys;
        phys_reg_t new_rd_phys;
        phys_reg_t old_rd_phys;
    } lane_map_t;

    // register handed back by retire
    typedef struct packed {
        logic      valid;
        phys_reg_t preg;
    } release_t;

endpackage

`default_nettype wire

// ==== source/spec_rat.sv ====
`timescale 1ns/1ps
`default_nettype none

module spec_rat
    import rename_pkg::*;
(
    input  wire               clock,
    input  wire               reset_n,
    input  wire decode_lane_t decode_i [LANES],
    input  wire phys_reg_t    alloc_i [LANES],
    input  wire               load_i,
    output lane_map_t         lookup_o [LANES]
);

    // speculative mapping, one entry per architectural register
    phys_reg_t rat_q [NUM_ARCH];

    //////////////////////////////
    // lookups
    //////////////////////////////

    // reads see the table before this bundle's own writes
    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            lookup_o[l].rs1_phys    = rat_q[decode_i[l].rs1];
            lookup_o[l].rs2_phys    = rat_q[decode_i[l].rs2];
            lookup_o[l].new_rd_phys = '0;
            lookup_o[l].old_rd_phys = rat_q[decode_i[l].rd];
        end
    end

    //////////////////////////////
    // updates
    //////////////////////////////

    // lanes written in order so the youngest writer of an rd wins
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                rat_q[i] <= phys_reg_t'(i);
            end
        end
        else if (load_i)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (decode_i[l].write_rd)
                begin
                    rat_q[decode_i[l].rd] <= alloc_i[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list
    import rename_pkg::*;
#(
    parameter int PHYS_REGS = 80
)
(
    input  wire               clock,
    input  wire               reset_n,
    input  wire decode_lane_t decode_i [LANES],
    input  wire               load_i,
    input  wire release_t     release_i [RETIRE_PORTS],
    output phys_reg_t         alloc_o [LANES],
    output logic              stall_o
);

    localparam int CAP   = PHYS_REGS - NUM_ARCH;
    localparam int PTR_W = $clog2(CAP);
    localparam int CNT_W = $clog2(CAP + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    phys_reg_t queue [CAP];
    ptr_t      head;
    ptr_t      tail;
    cnt_t      count;
    cnt_t      take;
    cnt_t      pop_cnt;
    cnt_t      push_cnt;
    ptr_t      push_ptr [RETIRE_PORTS];

    // circular increment where the step never exceeds one lap
    function automatic ptr_t ptr_add(ptr_t base, cnt_t step);
        int sum;
        sum = int'(base) + int'(step);
        if (sum >= CAP)
        begin
            sum = sum - CAP;
        end
        return ptr_t'(sum);
    endfunction

    //////////////////////////////
    // allocation
    //////////////////////////////

    // writers take consecutive head entries in lane order
    always_comb
    begin
        take = '0;
        for (int l = 0; l < LANES; l++)
        begin
            alloc_o[l] = '0;
            if (decode_i[l].write_rd)
            begin
                alloc_o[l] = queue[ptr_add(head, take)];
                take = take + 1'b1;
            end
        end
    end

    assign pop_cnt = load_i ? take : '0;
    assign stall_o = (count < cnt_t'(LANES));

    //////////////////////////////
    // release
    //////////////////////////////

    always_comb
    begin
        push_cnt = '0;
        for (int p = 0; p < RETIRE_PORTS; p++)
        begin
            push_ptr[p] = ptr_add(tail, push_cnt);
            if (release_i[p].valid)
            begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            // every register above the architectural range starts free
            for (int i = 0; i < CAP; i++)
            begin
                queue[i] <= phys_reg_t'(NUM_ARCH + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= cnt_t'(CAP);
        end
        else
        begin
            for (int p = 0; p < RETIRE_PORTS; p++)
            begin
                if (release_i[p].valid)
                begin
                    queue[push_ptr[p]] <= release_i[p].preg;
                end
            end
            head  <= ptr_add(head, pop_cnt);
            tail  <= ptr_add(tail, push_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    // decoder must honour stall before loading a bundle
    a_no_pop_short: assert property (@(posedge clock) disable iff (!reset_n)
        (pop_cnt != '0) |-> (count >= cnt_t'(LANES)));

    // retire only returns registers that were handed out
    a_no_overflow: assert property (@(posedge clock) disable iff (!reset_n)
        count <= cnt_t'(CAP));

endmodule

`default_nettype wire

// ==== source/dep_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module dep_check
    import rename_pkg::*;
(
    input  wire decode_lane_t decode_i [LANES],
    output lane_sel_t         sel_o [LANES]
);

    // replaces cur when the earlier lane writes the wanted register
    function automatic src_sel_t pick(
        src_sel_t     cur,
        arch_reg_t    want,
        decode_lane_t prev,
        int           idx
    );
        src_sel_t hit;
        hit.bypass = 1'b1;
        hit.lane   = lane_idx_t'(idx);
        if (prev.write_rd && (prev.rd == want))
        begin
            return hit;
        end
        return cur;
    endfunction

    //////////////////////////////
    // bundle compare
    //////////////////////////////

    // scan oldest to youngest so the nearest earlier writer is left in place
    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            sel_o[l] = '0;
            for (int j = 0; j < l; j++)
            begin
                sel_o[l].rs1    = pick(sel_o[l].rs1, decode_i[l].rs1, decode_i[j], j);
                sel_o[l].rs2    = pick(sel_o[l].rs2, decode_i[l].rs2, decode_i[j], j);
                sel_o[l].old_rd = pick(sel_o[l].old_rd, decode_i[l].rd, decode_i[j], j);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/map_override.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_override
    import rename_pkg::*;
(
    input  wire            clock,
    input  wire            reset_n,
    input  wire            load_i,
    input  wire lane_map_t lookup_i [LANES],
    input  wire phys_reg_t alloc_i [LANES],
    input  wire lane_sel_t sel_i [LANES],
    output lane_map_t      map_o [LANES]
);

    lane_map_t lookup_r [LANES];
    phys_reg_t alloc_r [LANES];
    lane_sel_t sel_r [LANES];
    lane_map_t merged [LANES];

    //////////////////////////////
    // stage one registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                lookup_r[l] <= '0;
                alloc_r[l]  <= '0;
                sel_r[l]    <= '0;
            end
        end
        else if (load_i)
        begin
            lookup_r <= lookup_i;
            alloc_r  <= alloc_i;
            sel_r    <= sel_i;
        end
    end

    //////////////////////////////
    // override
    //////////////////////////////

    // table values are stale for anything an earlier lane just renamed
    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            merged[l].rs1_phys = sel_r[l].rs1.bypass ?
                alloc_r[sel_r[l].rs1.lane] : lookup_r[l].rs1_phys;
            merged[l].rs2_phys = sel_r[l].rs2.bypass ?
                alloc_r[sel_r[l].rs2.lane] : lookup_r[l].rs2_phys;
            merged[l].old_rd_phys = sel_r[l].old_rd.bypass ?
                alloc_r[sel_r[l].old_rd.lane] : lookup_r[l].old_rd_phys;
            merged[l].new_rd_phys = alloc_r[l];
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                map_o[l] <= '0;
            end
        end
        else if (load_i)
        begin
            map_o <= merged;
        end
    end

    // dependency check may only point at older lanes of the bundle
    for (genvar l = 0; l < LANES; l++)
    begin : g_sel_order
        a_sel_older: assert property (@(posedge clock) disable iff (!reset_n)
            load_i |-> ((!sel_i[l].rs1.bypass || (sel_i[l].rs1.lane < l)) &&
                        (!sel_i[l].rs2.bypass || (sel_i[l].rs2.lane < l)) &&
                        (!sel_i[l].old_rd.bypass || (sel_i[l].old_rd.lane < l))));
    end

endmodule

`default_nettype wire

// ==== source/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top
    import rename_pkg::*;
#(
    parameter int PHYS_REGS = 80
)
(
    input  wire              clock,
    input  wire              reset_n,
    input  wire decode_lane_t decode_i [LANES],
    input  wire              load_i,
    input  wire release_t    release_i [RETIRE_PORTS],
    output lane_map_t        map_o [LANES],
    output logic             stall_o
);

    lane_map_t lookup [LANES];
    phys_reg_t alloc [LANES];
    lane_sel_t sel [LANES];

    //////////////////////////////
    // stage zero
    //////////////////////////////

    spec_rat u_spec_rat (
        .clock    (clock),
        .reset_n  (reset_n),
        .decode_i (decode_i),
        .alloc_i  (alloc),
        .load_i   (load_i),
        .lookup_o (lookup)
    );

    free_list #(
        .PHYS_REGS (PHYS_REGS)
    ) u_free_list (
        .clock     (clock),
        .reset_n   (reset_n),
        .decode_i  (decode_i),
        .load_i    (load_i),
        .release_i (release_i),
        .alloc_o   (alloc),
        .stall_o   (stall_o)
    );

    dep_check u_dep_check (
        .decode_i (decode_i),
        .sel_o    (sel)
    );

    //////////////////////////////
    // stage one and output
    //////////////////////////////

    map_override u_map_override (
        .clock    (clock),
        .reset_n  (reset_n),
        .load_i   (load_i),
        .lookup_i (lookup),
        .alloc_i  (alloc),
        .sel_i    (sel),
        .map_o    (map_o)
    );

endmodule

`default_nettype wire

// ==== verification/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef lane_map_t [LANES-1:0] bundle_t;

phys_reg_t m_rat [NUM_ARCH];
phys_reg_t m_free [$];
phys_reg_t m_retired [$];
bundle_t   m_inflight [$];
bundle_t   m_out;

task automatic model_reset();
    m_free.delete();
    m_retired.delete();
    m_inflight.delete();
    for (int i = 0; i < NUM_ARCH; i++)
    begin
        m_rat[i] = phys_reg_t'(i);
    end
    for (int i = NUM_ARCH; i < PHYS_REGS; i++)
    begin
        m_free.push_back(phys_reg_t'(i));
    end
    // stage one comes out of reset holding an all zero bundle
    m_inflight.push_back('0);
    m_out = '0;
endtask

// lanes are renamed oldest first, so later lanes see earlier writes
task automatic rename_lane(input decode_lane_t d, output lane_map_t m);
    m.rs1_phys    = m_rat[d.rs1];
    m.rs2_phys    = m_rat[d.rs2];
    m.old_rd_phys = m_rat[d.rd];
    m.new_rd_phys = '0;
    if (d.write_rd)
    begin
        m.new_rd_phys = m_free.pop_front();
        m_rat[d.rd]   = m.new_rd_phys;
        m_retired.push_back(m.old_rd_phys);
    end
endtask

task automatic accept_bundle(input bundle_t b);
    m_inflight.push_back(b);
    m_out = m_inflight.pop_front();
endtask

task automatic return_reg(input phys_reg_t p);
    m_free.push_back(p);
endtask

`endif

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb
    import rename_pkg::*;
();

    localparam int PHYS_REGS = 80;

    logic         clock;
    logic         reset_n;
    logic         load_in;
    decode_lane_t decode_in [LANES];
    release_t     release_in [RETIRE_PORTS];
    lane_map_t    map_out [LANES];
    logic         stall_out;

    int    seed;
    int    errors;
    int    checks;
    int    waited;
    int    stretch;
    string test_name;

    `include "rename_model.svh"

    rename_top #(
        .PHYS_REGS (PHYS_REGS)
    ) u_rename_top (
        .clock     (clock),
        .reset_n   (reset_n),
        .decode_i  (decode_in),
        .load_i    (load_in),
        .release_i (release_in),
        .map_o     (map_out),
        .stall_o   (stall_out)
    );

    always #4 clock = ~clock;

    //////////////////////////////
    // checks and stimulus
    //////////////////////////////

    task automatic check_outputs();
        for (int l = 0; l < LANES; l++)
        begin
            checks++;
            if (map_out[l] !== m_out[l])
            begin
                errors++;
                $display("CHECK FAILED %s lane %0d map: expected %h actual %h",
                         test_name, l, m_out[l], map_out[l]);
            end
        end
        checks++;
        if (stall_out !== (m_free.size() < LANES))
        begin
            errors++;
            $display("CHECK FAILED %s stall: expected %b actual %b",
                     test_name, (m_free.size() < LANES), stall_out);
        end
    endtask

    // one clock of checking, random drawing, model update and driving
    task automatic step(input int load_pct, input int rel_pct, input int reg_mask,
                        input bit distinct);
        bundle_t b;
        int      idx;
        int      base;
        logic    load;
        check_outputs();
        load = (($unsigned($random(seed)) % 100) < load_pct) && (m_free.size() >= LANES);
        base = $random(seed);
        for (int l = 0; l < LANES; l++)
        begin
            decode_in[l].rs1      = arch_reg_t'($random(seed) & reg_mask);
            decode_in[l].rs2      = arch_reg_t'($random(seed) & reg_mask);
            decode_in[l].rd       = distinct ? arch_reg_t'(base + l)
                                             : arch_reg_t'($random(seed) & reg_mask);
            decode_in[l].write_rd = ($random(seed) % 4) != 0;
        end
        // releases come only from registers already unmapped by a rename
        for (int p = 0; p < RETIRE_PORTS; p++)
        begin
            release_in[p] = '0;
            if ((m_retired.size() > 0) && (($unsigned($random(seed)) % 100) < rel_pct))
            begin
                idx = $unsigned($random(seed)) % m_retired.size();
                release_in[p].valid = 1'b1;
                release_in[p].preg  = m_retired[idx];
                m_retired.delete(idx);
            end
        end
        if (load)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                rename_lane(decode_in[l], b[l]);
            end
            accept_bundle(b);
        end
        for (int p = 0; p < RETIRE_PORTS; p++)
        begin
            if (release_in[p].valid)
            begin
                return_reg(release_in[p].preg);
            end
        end
        load_in = load;
        @(posedge clock);
        #1;
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial
    begin
        seed    = 58;
        errors  = 0;
        checks  = 0;
        clock   = 1'b0;
        reset_n = 1'b0;
        load_in = 1'b0;
        for (int l = 0; l < LANES; l++)
        begin
            decode_in[l] = '0;
        end
        for (int p = 0; p < RETIRE_PORTS; p++)
        begin
            release_in[p] = '0;
        end
        model_reset();
        repeat (2) @(posedge clock);
        #1;
        reset_n = 1'b1;

        test_name = "reset";
        check_outputs();

        test_name = "distinct";
        repeat (60) step(70, 50, 31, 1'b1);

        // narrow register range forces collisions inside a bundle
        test_name = "collide";
        repeat (60) step(70, 50, 3, 1'b0);

        test_name = "hold";
        repeat (20)
        begin
            stretch = 1 + ($unsigned($random(seed)) % 6);
            repeat (stretch) step(0, 50, 31, 1'b0);
            step(100, 50, 31, 1'b0);
        end

        test_name = "drain";
        waited = 0;
        while (!stall_out && (waited < 200))
        begin
            step(100, 0, 31, 1'b0);
            waited++;
        end
        if (!stall_out)
        begin
            errors++;
            $display("stall did not rise within 200 cycles without releases");
        end
        repeat (4) step(100, 0, 31, 1'b0);

        test_name = "refill";
        waited = 0;
        while (stall_out && (waited < 50))
        begin
            step(100, 100, 31, 1'b0);
            waited++;
        end
        if (stall_out)
        begin
            errors++;
            $display("stall did not clear within 50 cycles of releases");
        end
        repeat (40) step(70, 50, 31, 1'b0);

        test_name = "end";
        check_outputs();
        $display("checks %0d, failures %0d", checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verification
source/rename_pkg.sv
source/spec_rat.sv
source/free_list.sv
source/dep_check.sv
source/map_override.sv
source/rename_top.sv
verification/rename_tb.sv
